// File: logic/bus_pkg.sv
package bus_pkg;

    // wishbone side, fixed by the riscv core bus
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  sel_t;

    // ram side
    localparam int RAM_ADDR_W = 12;

    typedef logic [7:0]            byte_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

endpackage

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

    // which wishbone port a beat belongs to
    typedef enum logic {
        PORT_IF,
        PORT_DATA
    } port_t;

    // byte lane inside a 32-bit word
    typedef logic [1:0] lane_t;

    // beats buffered between arbiter and sequencer, keep a power of two
    localparam int FIFO_DEPTH = 4;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ISSUE,
        ARB_WAIT,
        ARB_ACK
    } arb_state_t;

endpackage

// File: logic/byte_ram.sv
`timescale 1ns/1ps

module byte_ram import bus_pkg::*; (
    input  logic      clk_in,
    input  logic      we,
    input  ram_addr_t addr,
    input  byte_t     d,
    output byte_t     q
);

    byte_t mem [0:(2**RAM_ADDR_W)-1];

    // read returns the old byte when written in the same cycle
    always_ff @(posedge clk_in) begin
        if (we) begin
            mem[addr] <= d;
        end
        q <= mem[addr];
    end

endmodule

// File: logic/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo import bus_pkg::*, ctrl_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      push,
    input  logic      pop,
    input  logic      we,
    input  ram_addr_t addr,
    input  byte_t     wbyte,
    input  lane_t     lane,
    input  logic      last,
    input  port_t     port,
    output logic      we_q,
    output ram_addr_t addr_q,
    output byte_t     wbyte_q,
    output lane_t     lane_q,
    output logic      last_q,
    output port_t     port_q,
    output logic      full,
    output logic      empty
);

    logic      we_mem    [0:FIFO_DEPTH-1];
    ram_addr_t addr_mem  [0:FIFO_DEPTH-1];
    byte_t     wbyte_mem [0:FIFO_DEPTH-1];
    lane_t     lane_mem  [0:FIFO_DEPTH-1];
    logic      last_mem  [0:FIFO_DEPTH-1];
    port_t     port_mem  [0:FIFO_DEPTH-1];

    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count_next;
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_comb begin
        case ({do_push, do_pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            // pointers wrap on their own since depth is a power of two
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
            full  <= (count_next == FIFO_DEPTH);
            empty <= (count_next == 0);
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            we_mem[wr_ptr]    <= we;
            addr_mem[wr_ptr]  <= addr;
            wbyte_mem[wr_ptr] <= wbyte;
            lane_mem[wr_ptr]  <= lane;
            last_mem[wr_ptr]  <= last;
            port_mem[wr_ptr]  <= port;
        end
    end

    // head entry is visible before the pop
    assign we_q    = we_mem[rd_ptr];
    assign addr_q  = addr_mem[rd_ptr];
    assign wbyte_q = wbyte_mem[rd_ptr];
    assign lane_q  = lane_mem[rd_ptr];
    assign last_q  = last_mem[rd_ptr];
    assign port_q  = port_mem[rd_ptr];

endmodule

// File: logic/ram_sequencer.sv
`timescale 1ns/1ps

module ram_sequencer import bus_pkg::*, ctrl_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      rdy_in,
    input  logic      empty,
    input  logic      we_q,
    input  ram_addr_t addr_q,
    input  byte_t     wbyte_q,
    input  lane_t     lane_q,
    input  logic      last_q,
    input  port_t     port_q,
    input  byte_t     ram_q,
    output logic      pop,
    output logic      ram_we,
    output ram_addr_t ram_addr,
    output byte_t     ram_d,
    output logic      done,
    output port_t     done_port,
    output word_t     done_data
);

    // read beat issued last cycle, its byte is on ram_q now
    logic  rd_pend;
    lane_t rd_lane;
    logic  rd_last;
    port_t rd_port;

    word_t asm_word;

    assign pop      = rdy_in && !empty;
    assign ram_we   = pop && we_q;
    assign ram_addr = addr_q;
    assign ram_d    = wbyte_q;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_pend   <= 1'b0;
            done      <= 1'b0;
            done_port <= PORT_IF;
            asm_word  <= '0;
        end else begin
            rd_pend <= pop && !we_q;
            done    <= 1'b0;

            // word has been handed over, start the next one from zero
            if (done) begin
                asm_word <= '0;
            end

            if (pop && we_q && last_q) begin
                done      <= 1'b1;
                done_port <= port_q;
            end

            if (rd_pend) begin
                asm_word[8*rd_lane +: 8] <= ram_q;
                if (rd_last) begin
                    done      <= 1'b1;
                    done_port <= rd_port;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (pop && !we_q) begin
            rd_lane <= lane_q;
            rd_last <= last_q;
            rd_port <= port_q;
        end
    end

    // zero for writes, as the word is cleared after every completion
    assign done_data = asm_word;

endmodule

// File: logic/req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter import bus_pkg::*, ctrl_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      if_cyc,
    input  logic      if_stb,
    input  addr_t     if_adr,
    output logic      if_ack,
    output word_t     if_dat_r,
    input  logic      d_cyc,
    input  logic      d_stb,
    input  logic      d_we,
    input  addr_t     d_adr,
    input  sel_t      d_sel,
    input  word_t     d_dat_w,
    output logic      d_ack,
    output word_t     d_dat_r,
    input  logic      fifo_full,
    input  logic      done,
    input  port_t     done_port,
    input  word_t     done_data,
    output logic      push,
    output logic      beat_we,
    output ram_addr_t beat_addr,
    output byte_t     beat_byte,
    output lane_t     beat_lane,
    output logic      beat_last,
    output port_t     beat_port
);

    arb_state_t state;

    logic      d_req;
    logic      if_req;
    port_t     cur_port;
    logic      cur_we;
    ram_addr_t cur_adr;
    word_t     cur_dat;
    lane_t     last_lane;
    lane_t     lane_cnt;
    word_t     rdata;

    // legal masks are 0001, 0011 and 1111
    function automatic lane_t sel_last_lane(input sel_t sel);
        if (sel[3]) return 2'd3;
        else if (sel[1]) return 2'd1;
        else return 2'd0;
    endfunction

    assign d_req  = d_cyc && d_stb;
    assign if_req = if_cyc && if_stb;

    // one beat per cycle while there is room
    assign push      = (state == ARB_ISSUE) && !fifo_full;
    assign beat_we   = cur_we;
    assign beat_addr = cur_adr + ram_addr_t'(lane_cnt);
    assign beat_byte = cur_dat[8*lane_cnt +: 8];
    assign beat_lane = lane_cnt;
    assign beat_last = (lane_cnt == last_lane);
    assign beat_port = cur_port;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state    <= ARB_IDLE;
            lane_cnt <= '0;
            if_ack   <= 1'b0;
            d_ack    <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    lane_cnt <= '0;
                    if (d_req || if_req) state <= ARB_ISSUE;
                end
                ARB_ISSUE: begin
                    if (push) begin
                        if (beat_last) state <= ARB_WAIT;
                        else lane_cnt <= lane_cnt + 1'b1;
                    end
                end
                ARB_WAIT: begin
                    if (done) begin
                        state  <= ARB_ACK;
                        if_ack <= (done_port == PORT_IF);
                        d_ack  <= (done_port == PORT_DATA);
                    end
                end
                ARB_ACK: begin
                    // master drops stb on this edge
                    if_ack <= 1'b0;
                    d_ack  <= 1'b0;
                    state  <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // request is captured while idle, data port first
    always_ff @(posedge clk_in) begin
        if (state == ARB_IDLE) begin
            if (d_req) begin
                cur_port  <= PORT_DATA;
                cur_we    <= d_we;
                cur_adr   <= d_adr[RAM_ADDR_W-1:0];
                cur_dat   <= d_dat_w;
                last_lane <= sel_last_lane(d_sel);
            end else begin
                cur_port  <= PORT_IF;
                cur_we    <= 1'b0;
                cur_adr   <= if_adr[RAM_ADDR_W-1:0];
                cur_dat   <= '0;
                last_lane <= 2'd3;
            end
        end
        if (state == ARB_WAIT && done) begin
            rdata <= done_data;
        end
    end

    assign if_dat_r = rdata;
    assign d_dat_r  = rdata;

endmodule

// File: logic/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys import bus_pkg::*, ctrl_pkg::*; (
    input  logic  clk_in,
    input  logic  rst_in,
    input  logic  rdy_in,
    input  logic  if_cyc,
    input  logic  if_stb,
    input  addr_t if_adr,
    output word_t if_dat_r,
    output logic  if_ack,
    input  logic  d_cyc,
    input  logic  d_stb,
    input  logic  d_we,
    input  addr_t d_adr,
    input  sel_t  d_sel,
    input  word_t d_dat_w,
    output word_t d_dat_r,
    output logic  d_ack
);

    // arbiter to fifo
    logic      push;
    logic      beat_we;
    ram_addr_t beat_addr;
    byte_t     beat_byte;
    lane_t     beat_lane;
    logic      beat_last;
    port_t     beat_port;
    logic      fifo_full;

    // fifo head to sequencer
    logic      pop;
    logic      fifo_empty;
    logic      we_q;
    ram_addr_t addr_q;
    byte_t     wbyte_q;
    lane_t     lane_q;
    logic      last_q;
    port_t     port_q;

    // completion back to arbiter
    logic      done;
    port_t     done_port;
    word_t     done_data;

    logic      ram_we;
    ram_addr_t ram_addr;
    byte_t     ram_d;
    byte_t     ram_q;

    req_arbiter u_arbiter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .if_cyc    (if_cyc),
        .if_stb    (if_stb),
        .if_adr    (if_adr),
        .if_ack    (if_ack),
        .if_dat_r  (if_dat_r),
        .d_cyc     (d_cyc),
        .d_stb     (d_stb),
        .d_we      (d_we),
        .d_adr     (d_adr),
        .d_sel     (d_sel),
        .d_dat_w   (d_dat_w),
        .d_ack     (d_ack),
        .d_dat_r   (d_dat_r),
        .fifo_full (fifo_full),
        .done      (done),
        .done_port (done_port),
        .done_data (done_data),
        .push      (push),
        .beat_we   (beat_we),
        .beat_addr (beat_addr),
        .beat_byte (beat_byte),
        .beat_lane (beat_lane),
        .beat_last (beat_last),
        .beat_port (beat_port)
    );

    beat_fifo u_fifo (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .push    (push),
        .pop     (pop),
        .we      (beat_we),
        .addr    (beat_addr),
        .wbyte   (beat_byte),
        .lane    (beat_lane),
        .last    (beat_last),
        .port    (beat_port),
        .we_q    (we_q),
        .addr_q  (addr_q),
        .wbyte_q (wbyte_q),
        .lane_q  (lane_q),
        .last_q  (last_q),
        .port_q  (port_q),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    ram_sequencer u_sequencer (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .rdy_in    (rdy_in),
        .empty     (fifo_empty),
        .we_q      (we_q),
        .addr_q    (addr_q),
        .wbyte_q   (wbyte_q),
        .lane_q    (lane_q),
        .last_q    (last_q),
        .port_q    (port_q),
        .ram_q     (ram_q),
        .pop       (pop),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_d     (ram_d),
        .done      (done),
        .done_port (done_port),
        .done_data (done_data)
    );

    byte_ram u_ram (
        .clk_in (clk_in),
        .we     (ram_we),
        .addr   (ram_addr),
        .d      (ram_d),
        .q      (ram_q)
    );

endmodule

// File: verif/mem_subsys_sva.sv
`timescale 1ns/1ps

module mem_subsys_sva (
    input logic clk_in,
    input logic rst_in,
    input logic if_cyc,
    input logic if_stb,
    input logic if_ack,
    input logic d_cyc,
    input logic d_stb,
    input logic d_ack,
    input logic pop,
    input logic fifo_full
);

    ack_exclusive: assert property (@(posedge clk_in) disable iff (rst_in)
        !(if_ack && d_ack))
        else $error("fetch and data acknowledge high together");

    if_ack_in_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(if_ack) |-> (if_cyc && if_stb))
        else $error("fetch acknowledge without an open cycle");

    d_ack_in_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(d_ack) |-> (d_cyc && d_stb))
        else $error("data acknowledge without an open cycle");

    // a full fifo only drains through a pop, a push there must not count
    full_holds_without_pop: assert property (@(posedge clk_in) disable iff (rst_in)
        (fifo_full && !pop) |=> fifo_full)
        else $error("FIFO left the full state without a pop");

    acks_low_in_reset: assert property (@(posedge clk_in)
        $past(rst_in) |-> (!if_ack && !d_ack))
        else $error("acknowledge high during reset");

endmodule

bind mem_subsys mem_subsys_sva u_sva (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .if_cyc    (if_cyc),
    .if_stb    (if_stb),
    .if_ack    (if_ack),
    .d_cyc     (d_cyc),
    .d_stb     (d_stb),
    .d_ack     (d_ack),
    .pop       (pop),
    .fifo_full (fifo_full)
);

// File: verif/mem_subsys_checker.sv
`timescale 1ns/1ps

module mem_subsys_checker import bus_pkg::*; (
    input  logic  clk_in,
    input  logic  rst_in,
    input  logic  arm,
    input  logic  exp_d_en,
    input  logic  exp_d_chk,
    input  word_t exp_d_data,
    input  logic  exp_if_en,
    input  word_t exp_if_data,
    input  logic  if_ack,
    input  word_t if_dat_r,
    input  logic  d_ack,
    input  word_t d_dat_r,
    output int    checks,
    output int    errors
);

    int   check_cnt = 0;
    int   err_cnt = 0;
    logic d_pend = 1'b0;
    logic if_pend = 1'b0;
    logic d_chk = 1'b0;
    word_t d_want;
    word_t if_want;

    assign checks = check_cnt;
    assign errors = err_cnt;

    // outputs are registered, so the middle of the cycle is stable
    always @(negedge clk_in) begin
        if (rst_in) begin
            d_pend = 1'b0;
            if_pend = 1'b0;
            if (if_ack || d_ack) begin
                err_cnt = err_cnt + 1;
                $display("acknowledge seen while reset is asserted at %0t", $time);
            end
        end else begin
            if (arm) begin
                d_pend = exp_d_en;
                d_chk = exp_d_chk;
                d_want = exp_d_data;
                if_pend = exp_if_en;
                if_want = exp_if_data;
            end
            if (d_ack) begin
                if (!d_pend) begin
                    err_cnt = err_cnt + 1;
                    $display("data port acknowledged with no request open at %0t", $time);
                end else if (d_chk) begin
                    check_cnt = check_cnt + 1;
                    if (d_dat_r !== d_want) begin
                        err_cnt = err_cnt + 1;
                        $display("ERROR at %0t: d_dat_r is 0x%08h, expected 0x%08h",
                                 $time, d_dat_r, d_want);
                    end
                end
                d_pend = 1'b0;
            end
            if (if_ack) begin
                check_cnt = check_cnt + 1;
                if (!if_pend) begin
                    err_cnt = err_cnt + 1;
                    $display("fetch port acknowledged with no request open at %0t", $time);
                end else if (d_pend) begin
                    // data has priority when both are raised together
                    err_cnt = err_cnt + 1;
                    $display("fetch acknowledge came before the data acknowledge at %0t",
                             $time);
                end else if (if_dat_r !== if_want) begin
                    err_cnt = err_cnt + 1;
                    $display("ERROR at %0t: if_dat_r is 0x%08h, expected 0x%08h",
                             $time, if_dat_r, if_want);
                end
                if_pend = 1'b0;
            end
        end
    end

endmodule

// File: verif/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb import bus_pkg::*; ();

    logic  clk_in;
    logic  rst_in;
    logic  rdy_in;
    logic  if_cyc;
    logic  if_stb;
    addr_t if_adr;
    word_t if_dat_r;
    logic  if_ack;
    logic  d_cyc;
    logic  d_stb;
    logic  d_we;
    addr_t d_adr;
    sel_t  d_sel;
    word_t d_dat_w;
    word_t d_dat_r;
    logic  d_ack;

    // expectations handed to the checker
    logic  arm;
    logic  exp_d_en;
    logic  exp_d_chk;
    word_t exp_d_data;
    logic  exp_if_en;
    word_t exp_if_data;
    int    checks;
    int    errors;

    int    t_num[$];
    int    t_op[$];
    addr_t t_adr[$];
    sel_t  t_sel[$];
    word_t t_wdat[$];
    logic  t_stall[$];
    word_t t_exp[$];

    logic        stall_on;
    logic [31:0] lfsr_state;
    int          cycles;
    int          limit;
    int          tests_failed;

    mem_subsys uut (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .rdy_in   (rdy_in),
        .if_cyc   (if_cyc),
        .if_stb   (if_stb),
        .if_adr   (if_adr),
        .if_dat_r (if_dat_r),
        .if_ack   (if_ack),
        .d_cyc    (d_cyc),
        .d_stb    (d_stb),
        .d_we     (d_we),
        .d_adr    (d_adr),
        .d_sel    (d_sel),
        .d_dat_w  (d_dat_w),
        .d_dat_r  (d_dat_r),
        .d_ack    (d_ack)
    );

    mem_subsys_checker u_checker (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .arm         (arm),
        .exp_d_en    (exp_d_en),
        .exp_d_chk   (exp_d_chk),
        .exp_d_data  (exp_d_data),
        .exp_if_en   (exp_if_en),
        .exp_if_data (exp_if_data),
        .if_ack      (if_ack),
        .if_dat_r    (if_dat_r),
        .d_ack       (d_ack),
        .d_dat_r     (d_dat_r),
        .checks      (checks),
        .errors      (errors)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, a request was never acknowledged", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // unselected lanes read back as zero
    function automatic word_t lane_mask(input sel_t sel);
        word_t m;
        m = '0;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) m[8*i +: 8] = 8'hff;
        end
        return m;
    endfunction

    function automatic string op_name(input int op);
        case (op)
            0:       return "data write";
            1:       return "data read";
            2:       return "fetch";
            default: return "read and fetch";
        endcase
    endfunction

    task automatic step();
        @(posedge clk_in);
        #2;
        arm = 1'b0;
        if (stall_on) begin
            lfsr_state = lfsr_next(lfsr_state);
            rdy_in = lfsr_state[0];
        end else begin
            rdy_in = 1'b1;
        end
    endtask

    task automatic load_tests(output bit ok);
        int fd;
        int n;
        int num;
        int op;
        int stall;
        logic [31:0] adr;
        logic [31:0] sel;
        logic [31:0] wdat;
        logic [31:0] expv;
        string line;
        ok = 1'b0;
        fd = $fopen("verif/mem_subsys_input.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0) break;
            if (line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%d %h %h %h %h %d %h", num, op, adr, sel, wdat, stall, expv);
            if (n == 7) begin
                t_num.push_back(num);
                t_op.push_back(op);
                t_adr.push_back(adr);
                t_sel.push_back(sel[3:0]);
                t_wdat.push_back(wdat);
                t_stall.push_back(stall != 0);
                t_exp.push_back(expv);
            end
        end
        $fclose(fd);
        ok = (t_num.size() > 0);
    endtask

    task automatic run_test(input int idx);
        int  op;
        int  err_before;
        bit  d_wait;
        bit  f_wait;
        bit  d_drop;
        bit  f_drop;
        op = t_op[idx];
        err_before = errors;
        stall_on = t_stall[idx];
        d_wait = (op != 2);
        f_wait = (op >= 2);
        d_drop = 1'b0;
        f_drop = 1'b0;

        exp_d_en = d_wait;
        exp_d_chk = (op == 1 || op == 3);
        exp_d_data = t_exp[idx] & lane_mask(t_sel[idx]);
        exp_if_en = f_wait;
        exp_if_data = t_exp[idx];
        arm = 1'b1;

        if (d_wait) begin
            d_cyc = 1'b1;
            d_stb = 1'b1;
            d_we = (op == 0);
            d_adr = t_adr[idx];
            d_sel = t_sel[idx];
            d_dat_w = t_wdat[idx];
        end
        if (f_wait) begin
            if_cyc = 1'b1;
            if_stb = 1'b1;
            if_adr = t_adr[idx];
        end

        // a port lets go one edge after its ack was seen
        while (d_wait || f_wait || d_drop || f_drop) begin
            step();
            if (d_drop) begin
                d_cyc = 1'b0;
                d_stb = 1'b0;
                d_we = 1'b0;
                d_drop = 1'b0;
            end
            if (f_drop) begin
                if_cyc = 1'b0;
                if_stb = 1'b0;
                f_drop = 1'b0;
            end
            if (d_wait && d_ack) begin
                d_wait = 1'b0;
                d_drop = 1'b1;
            end
            if (f_wait && if_ack) begin
                f_wait = 1'b0;
                f_drop = 1'b1;
            end
        end

        if (errors != err_before) tests_failed = tests_failed + 1;
        $display("test %0d %s at 0x%08h: %s", t_num[idx], op_name(op), t_adr[idx],
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        bit file_ok;
        rst_in = 1'b1;
        rdy_in = 1'b1;
        if_cyc = 1'b0;
        if_stb = 1'b0;
        if_adr = '0;
        d_cyc = 1'b0;
        d_stb = 1'b0;
        d_we = 1'b0;
        d_adr = '0;
        d_sel = '0;
        d_dat_w = '0;
        arm = 1'b0;
        exp_d_en = 1'b0;
        exp_d_chk = 1'b0;
        exp_d_data = '0;
        exp_if_en = 1'b0;
        exp_if_data = '0;
        stall_on = 1'b0;
        lfsr_state = 32'h62fb_a980;
        cycles = 0;
        limit = 0;
        tests_failed = 0;

        load_tests(file_ok);
        limit = 64 * t_num.size() + 200;

        repeat (16) @(posedge clk_in);
        #2;
        rst_in = 1'b0;
        step();

        if (file_ok) begin
            for (int i = 0; i < t_num.size(); i++) begin
                run_test(i);
                step();
            end
        end else begin
            $display("stimulus file verif/mem_subsys_input.txt could not be read");
        end
        step();
        step();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 t_num.size(), tests_failed, checks, errors);
        if (file_ok && errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verif/mem_subsys_input.txt
# test op addr sel wdata stall expected (op, addr, sel, wdata and expected in hex)
# op 0 data write, 1 data read, 2 fetch, 3 data read and fetch raised together
1 0 00000100 f 11223344 0 00000000
2 2 00000100 f 00000000 0 11223344
3 1 00000100 f 00000000 0 11223344
4 0 00000200 1 000000aa 0 00000000
5 0 00000201 3 0000ccbb 0 00000000
6 0 00000203 1 000000dd 0 00000000
7 1 00000200 f 00000000 0 ddccbbaa
8 1 00000201 3 00000000 0 0000ccbb
9 1 00000202 1 00000000 0 000000cc
10 0 00000202 3 0000ffee 0 00000000
11 1 00000200 f 00000000 0 ffeebbaa
12 1 00000200 3 00000000 0 0000bbaa
13 0 00000300 f cafef00d 0 00000000
14 3 00000300 3 00000000 0 cafef00d
15 3 00000200 1 00000000 0 ffeebbaa
16 0 00000400 f 01020304 1 00000000
17 0 00000404 3 0000a5a5 1 00000000
18 1 00000400 f 00000000 1 01020304
19 1 00000403 3 00000000 1 0000a501
20 3 00000400 1 00000000 1 01020304
21 0 00001004 f 89abcdef 0 00000000
22 1 00000004 f 00000000 0 89abcdef
23 2 00002004 f 00000000 0 89abcdef
24 0 00000ffe f 76543210 0 00000000
25 1 00000000 3 00000000 1 00007654
26 2 00001ffe f 00000000 1 76543210
27 1 00000006 1 00000000 0 000000ab
28 0 00000500 f deadbeef 1 00000000
29 3 00000500 f 00000000 1 deadbeef

// File: mem_subsys.f
logic/bus_pkg.sv
logic/ctrl_pkg.sv
logic/byte_ram.sv
logic/beat_fifo.sv
logic/ram_sequencer.sv
logic/req_arbiter.sv
logic/mem_subsys.sv
verif/mem_subsys_sva.sv
verif/mem_subsys_checker.sv
verif/mem_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mem_subsys_tb \
    -f mem_subsys.f -Mdir obj_dir -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mem_subsys_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished without failure"
exit 0
